//--- fixedPointPkg.sv
package fixedPointPkg;

  // All formats share the same binary point position.
  localparam int FracBits = 9;

  // Width of one ray-direction component.
  // The collector and the top level also use it to pack the lane buses.
  localparam int RayDirBits = 13;

  // Player position, unsigned 6.9.
  // Covers a 64x64 map at 1/512 of a block.
  typedef logic [14:0] uq6_9_t;

  // Facing, plane and camera X values, signed 2.9.
  // The range [-2.0, +2.0) leaves headroom over unit vectors.
  typedef logic signed [10:0] sq2_9_t;

  // Full product of two sq2_9_t values.
  typedef logic signed [21:0] sq4_18_t;

  // Ray-direction component, signed 3.9.
  // Facing plus a scaled plane component stays inside (-4.0, +4.0).
  typedef logic signed [RayDirBits-1:0] rayDir_t;

endpackage

//--- povFramePkg.sv
package povFramePkg;

  import fixedPointPkg::*;

  // One SPI frame, MSB first.
  // Field order is playerX, playerY, facingX, facingY, planeX, planeY.
  // That is 2x15 + 2x11 + 2x11 bits.
  localparam int FrameBits = 74;

  // Whole frame as shifted in.
  typedef logic [FrameBits-1:0] frame_t;

  // Bit counter, counts 0 to FrameBits-1.
  typedef logic [6:0] spiCount_t;

  // Demo starting point, loaded into the live registers on reset.
  // Each value is the real value times 512, truncated toward zero.

  // 11.5 and 10.5.
  localparam uq6_9_t PlayerInitX = 15'd5888;
  localparam uq6_9_t PlayerInitY = 15'd5376;

  // 0.720137 and -0.693832.
  localparam sq2_9_t FacingInitX = 11'sd368;
  localparam sq2_9_t FacingInitY = -11'sd355;

  // 0.346916 and 0.360069.
  localparam sq2_9_t PlaneInitX = 11'sd177;
  localparam sq2_9_t PlaneInitY = 11'sd184;

endpackage

//--- spiSync.sv
`timescale 1ns/1ps

module spiSync (
  input  logic clk,
  input  logic reset,
  input  logic i_sclk,
  input  logic i_ssN,
  input  logic i_mosi,
  output logic o_sclkRise,
  output logic o_ssActive,
  output logic o_mosi
);

  // SCLK gets a third stage so the two older stages can see an edge.
  logic [2:0] sclkBuf;

  // /SS and MOSI only need the usual two-flop pair.
  logic [1:0] ssBuf;
  logic [1:0] mosiBuf;

  always_ff @(posedge clk) begin
    if (reset) begin
      sclkBuf <= '0;
      ssBuf   <= '0;
      mosiBuf <= '0;
    end else begin
      sclkBuf <= {sclkBuf[1:0], i_sclk};
      ssBuf   <= {ssBuf[0], i_ssN};
      mosiBuf <= {mosiBuf[0], i_mosi};
    end
  end

  // Rising edge seen between stages two and three.
  assign o_sclkRise = (sclkBuf[2:1] == 2'b01);

  // Select is active low on the pin.
  assign o_ssActive = ~ssBuf[1];

  // MOSI is stable long before the edge is seen.
  assign o_mosi = mosiBuf[1];

endmodule

//--- povLoader.sv
`timescale 1ns/1ps

module povLoader
  import fixedPointPkg::*;
  import povFramePkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   i_sclkRise,
  input  logic   i_ssActive,
  input  logic   i_mosi,
  input  logic   i_loadTick,
  input  logic   i_incPx,
  input  logic   i_incPy,
  output uq6_9_t o_playerX,
  output uq6_9_t o_playerY,
  output sq2_9_t o_facingX,
  output sq2_9_t o_facingY,
  output sq2_9_t o_planeX,
  output sq2_9_t o_planeY,
  output logic   o_povUpdated
);

  // Index of the bit expected next.
  spiCount_t spiCount;

  // Frame being shifted in.
  frame_t shiftBuf;

  // Pulses once the last bit is in shiftBuf.
  logic frameDone;

  // Last complete frame, waiting to go live.
  logic   ready;
  frame_t readyBuf;

  logic bitTake;
  logic frameEnd;
  logic incAny;

  // A bit is taken only on an SCLK edge inside a select window.
  assign bitTake  = i_ssActive && i_sclkRise;
  assign frameEnd = (spiCount == spiCount_t'(FrameBits - 1));

  // Demo override, decrements position on a tick.
  assign incAny = i_incPx || i_incPy;

  // Bit counter.
  // Dropping /SS discards any partial frame.
  always_ff @(posedge clk) begin
    if (reset) begin
      spiCount <= '0;
    end else if (!i_ssActive) begin
      spiCount <= '0;
    end else if (i_sclkRise) begin
      spiCount <= frameEnd ? '0 : spiCount + 1'b1;
    end
  end

  // Shift register, MSB first.
  // Left as is when a frame is aborted.
  always_ff @(posedge clk) begin
    if (bitTake) begin
      shiftBuf <= {shiftBuf[FrameBits-2:0], i_mosi};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      frameDone <= 1'b0;
    end else begin
      frameDone <= bitTake && frameEnd;
    end
  end

  // Ready stays set, so later ticks reload the same frame.
  // An override tick drops the buffered frame.
  always_ff @(posedge clk) begin
    if (reset) begin
      ready <= 1'b0;
    end else if (i_loadTick && incAny) begin
      ready <= 1'b0;
    end else if (frameDone) begin
      ready <= 1'b1;
    end
  end

  // Double buffer, frees shiftBuf for the next frame.
  always_ff @(posedge clk) begin
    if (frameDone) begin
      readyBuf <= shiftBuf;
    end
  end

  // Live POV registers.
  // Override has priority over the buffered load.
  always_ff @(posedge clk) begin
    if (reset) begin
      o_playerX <= PlayerInitX;
      o_playerY <= PlayerInitY;
      o_facingX <= FacingInitX;
      o_facingY <= FacingInitY;
      o_planeX  <= PlaneInitX;
      o_planeY  <= PlaneInitY;
    end else if (i_loadTick && incAny) begin
      // Wraps below zero.
      if (i_incPx) begin
        o_playerX <= o_playerX - 1'b1;
      end
      if (i_incPy) begin
        o_playerY <= o_playerY - 1'b1;
      end
    end else if (i_loadTick && ready) begin
      {o_playerX, o_playerY, o_facingX, o_facingY, o_planeX, o_planeY} <= readyBuf;
    end
  end

  // Every tick restarts the lanes, loaded or not.
  always_ff @(posedge clk) begin
    if (reset) begin
      o_povUpdated <= 1'b0;
    end else begin
      o_povUpdated <= i_loadTick;
    end
  end

  // SCLK edges are several clk cycles apart, so a frame cannot end twice in a row.
  assert property (@(posedge clk) disable iff (reset) frameDone |=> !frameDone);

  // Counter wraps at the frame length.
  assert property (@(posedge clk) disable iff (reset)
    spiCount <= spiCount_t'(FrameBits - 1));

endmodule

//--- rayDirLane.sv
`timescale 1ns/1ps

module rayDirLane
  import fixedPointPkg::*;
#(
  parameter int NumLanes  = 4,
  parameter int LaneIndex = 0
) (
  input  logic    clk,
  input  logic    reset,
  input  sq2_9_t  i_facingX,
  input  sq2_9_t  i_facingY,
  input  sq2_9_t  i_planeX,
  input  sq2_9_t  i_planeY,
  input  logic    i_start,
  output rayDir_t o_dirX,
  output rayDir_t o_dirY,
  output logic    o_valid
);

  // Camera X of this column is (2*LaneIndex+1)/NumLanes - 1, scaled by 512.
  // Integer division truncates toward zero.
  localparam int     CamNum = (2 * LaneIndex + 1 - NumLanes) * (1 << FracBits);
  localparam sq2_9_t CamX   = sq2_9_t'(CamNum / NumLanes);

  // Stage one.
  sq4_18_t prodX;
  sq4_18_t prodY;
  sq2_9_t  facingXq;
  sq2_9_t  facingYq;
  logic    validS1;

  // Products back to 9 fractional bits, floor.
  rayDir_t prodShX;
  rayDir_t prodShY;

  assign prodShX = rayDir_t'(prodX >>> FracBits);
  assign prodShY = rayDir_t'(prodY >>> FracBits);

  // Facing is captured with the products so both stages see one POV.
  always_ff @(posedge clk) begin
    if (i_start) begin
      prodX    <= i_planeX * CamX;
      prodY    <= i_planeY * CamX;
      facingXq <= i_facingX;
      facingYq <= i_facingY;
    end
  end

  // Stage two, facing sign-extended into 3.9.
  always_ff @(posedge clk) begin
    if (validS1) begin
      o_dirX <= rayDir_t'(facingXq) + prodShX;
      o_dirY <= rayDir_t'(facingYq) + prodShY;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      validS1 <= 1'b0;
      o_valid <= 1'b0;
    end else begin
      validS1 <= i_start;
      o_valid <= validS1;
    end
  end

endmodule

//--- rayCollector.sv
`timescale 1ns/1ps

module rayCollector
  import fixedPointPkg::*;
#(
  parameter int NumLanes = 4
) (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [NumLanes*RayDirBits-1:0] i_laneDirX,
  input  logic [NumLanes*RayDirBits-1:0] i_laneDirY,
  input  logic [NumLanes-1:0]            i_laneValid,
  output rayDir_t                        o_rayDirX,
  output rayDir_t                        o_rayDirY,
  output logic [3:0]                     o_rayIndex,
  output logic                           o_rayValid
);

  typedef enum logic {
    Idle,
    Emit
  } state_t;

  state_t state;

  // Snapshot of all lanes, taken once per tick.
  logic [NumLanes*RayDirBits-1:0] capX;
  logic [NumLanes*RayDirBits-1:0] capY;

  // Lane being emitted.
  logic [3:0] laneIdx;

  logic allValid;
  logic lastLane;

  // Lanes run in lockstep.
  assign allValid = &i_laneValid;
  assign lastLane = (laneIdx == 4'(NumLanes - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= Idle;
      laneIdx <= '0;
    end else begin
      case (state)
        Idle: begin
          if (allValid) begin
            state   <= Emit;
            laneIdx <= '0;
          end
        end
        Emit: begin
          // One lane per cycle, back to idle after the last.
          if (lastLane) begin
            state   <= Idle;
            laneIdx <= '0;
          end else begin
            laneIdx <= laneIdx + 1'b1;
          end
        end
        default: state <= Idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == Idle && allValid) begin
      capX <= i_laneDirX;
      capY <= i_laneDirY;
    end
  end

  assign o_rayValid = (state == Emit);
  assign o_rayIndex = laneIdx;
  assign o_rayDirX  = capX[laneIdx*RayDirBits +: RayDirBits];
  assign o_rayDirY  = capY[laneIdx*RayDirBits +: RayDirBits];

  // All lanes start together, so their valid bits agree.
  assert property (@(posedge clk) disable iff (reset)
    (i_laneValid == '0) || allValid);

  // Ticks must be spaced so a new result set never lands mid-burst.
  assert property (@(posedge clk) disable iff (reset)
    (state == Emit) |-> !(|i_laneValid));

endmodule

//--- povRaycastTop.sv
`timescale 1ns/1ps

module povRaycastTop
  import fixedPointPkg::*;
#(
  parameter int NumLanes = 4
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       i_sclk,
  input  logic       i_ssN,
  input  logic       i_mosi,
  input  logic       i_loadTick,
  input  logic       i_incPx,
  input  logic       i_incPy,
  output uq6_9_t     o_playerX,
  output uq6_9_t     o_playerY,
  output sq2_9_t     o_facingX,
  output sq2_9_t     o_facingY,
  output sq2_9_t     o_planeX,
  output sq2_9_t     o_planeY,
  output rayDir_t    o_rayDirX,
  output rayDir_t    o_rayDirY,
  output logic [3:0] o_rayIndex,
  output logic       o_rayValid
);

  logic sclkRise;
  logic ssActive;
  logic mosiSync;
  logic povUpdated;

  // Packed per-lane results, lane 0 in the low bits.
  logic [NumLanes*RayDirBits-1:0] laneDirX;
  logic [NumLanes*RayDirBits-1:0] laneDirY;
  logic [NumLanes-1:0]            laneValid;

  spiSync uSync (
    .clk        (clk),
    .reset      (reset),
    .i_sclk     (i_sclk),
    .i_ssN      (i_ssN),
    .i_mosi     (i_mosi),
    .o_sclkRise (sclkRise),
    .o_ssActive (ssActive),
    .o_mosi     (mosiSync)
  );

  povLoader uLoader (
    .clk          (clk),
    .reset        (reset),
    .i_sclkRise   (sclkRise),
    .i_ssActive   (ssActive),
    .i_mosi       (mosiSync),
    .i_loadTick   (i_loadTick),
    .i_incPx      (i_incPx),
    .i_incPy      (i_incPy),
    .o_playerX    (o_playerX),
    .o_playerY    (o_playerY),
    .o_facingX    (o_facingX),
    .o_facingY    (o_facingY),
    .o_planeX     (o_planeX),
    .o_planeY     (o_planeY),
    .o_povUpdated (povUpdated)
  );

  // One lane per screen column.
  for (genvar lane = 0; lane < NumLanes; lane++) begin : gLane
    rayDirLane #(
      .NumLanes  (NumLanes),
      .LaneIndex (lane)
    ) uLane (
      .clk       (clk),
      .reset     (reset),
      .i_facingX (o_facingX),
      .i_facingY (o_facingY),
      .i_planeX  (o_planeX),
      .i_planeY  (o_planeY),
      .i_start   (povUpdated),
      .o_dirX    (laneDirX[lane*RayDirBits +: RayDirBits]),
      .o_dirY    (laneDirY[lane*RayDirBits +: RayDirBits]),
      .o_valid   (laneValid[lane])
    );
  end

  rayCollector #(
    .NumLanes (NumLanes)
  ) uCollector (
    .clk         (clk),
    .reset       (reset),
    .i_laneDirX  (laneDirX),
    .i_laneDirY  (laneDirY),
    .i_laneValid (laneValid),
    .o_rayDirX   (o_rayDirX),
    .o_rayDirY   (o_rayDirY),
    .o_rayIndex  (o_rayIndex),
    .o_rayValid  (o_rayValid)
  );

endmodule

//--- povRaycastTb.sv
`timescale 1ns/1ps

module povRaycastTb;

  localparam int NumLanes = 4;
  localparam int FrameBits = 74;
  localparam int FracBits = 9;

  // SCLK half period in clk cycles.
  localparam int HalfCycles = 4;

  // Random rounds in the last test phase.
  localparam int RandomRounds = 8;

  // Frames and ticks sent over the whole run.
  localparam int FrameCount = 3 + RandomRounds;
  localparam int TickCount = 9 + 2 * RandomRounds;
  localparam int TickSpacing = NumLanes + 6;
  localparam int IdleCycles = 30;

  // Twice the expected run length in ns.
  localparam int WatchdogNs = 2 * (FrameCount * FrameBits * 8 * 20
                                   + TickCount * TickSpacing * 20 + IdleCycles * 20);

  // Init values as real values times 512 truncated toward zero.
  localparam logic [14:0]        InitPlayerX = 15'd5888;
  localparam logic [14:0]        InitPlayerY = 15'd5376;
  localparam logic signed [10:0] InitFacingX = 11'sd368;
  localparam logic signed [10:0] InitFacingY = -11'sd355;
  localparam logic signed [10:0] InitPlaneX = 11'sd177;
  localparam logic signed [10:0] InitPlaneY = 11'sd184;

  logic clk;
  logic reset;
  logic sclk;
  logic ssN;
  logic mosi;
  logic loadTick;
  logic incPx;
  logic incPy;

  logic [14:0]        playerX;
  logic [14:0]        playerY;
  logic signed [10:0] facingX;
  logic signed [10:0] facingY;
  logic signed [10:0] planeX;
  logic signed [10:0] planeY;
  logic signed [12:0] rayDirX;
  logic signed [12:0] rayDirY;
  logic [3:0]         rayIndex;
  logic               rayValid;

  // Reference model state.
  logic                 mReady;
  logic [FrameBits-1:0] mBuf;
  logic [14:0]          mPlayerX;
  logic [14:0]          mPlayerY;
  logic signed [10:0]   mFacingX;
  logic signed [10:0]   mFacingY;
  logic signed [10:0]   mPlaneX;
  logic signed [10:0]   mPlaneY;

  int seed = 32'h622cf1ad;
  logic [FrameBits-1:0] frame;

  povRaycastTop #(
    .NumLanes (NumLanes)
  ) uut (
    .clk        (clk),
    .reset      (reset),
    .i_sclk     (sclk),
    .i_ssN      (ssN),
    .i_mosi     (mosi),
    .i_loadTick (loadTick),
    .i_incPx    (incPx),
    .i_incPy    (incPy),
    .o_playerX  (playerX),
    .o_playerY  (playerY),
    .o_facingX  (facingX),
    .o_facingY  (facingY),
    .o_planeX   (planeX),
    .o_planeY   (planeY),
    .o_rayDirX  (rayDirX),
    .o_rayDirY  (rayDirY),
    .o_rayIndex (rayIndex),
    .o_rayValid (rayValid)
  );

  always #10 clk = ~clk;

  task automatic checkValue(input string label, input int actual, input int expected);
    if (actual !== expected) begin
      $display("mismatch at time %0t: %s got %0d, expected %0d", $time, label, actual, expected);
      $display("Test failed");
      $fatal(1, "value check failed");
    end
  endtask

  // Wait n edges, then step past the edge to the drive point.
  task automatic waitCycles(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  function automatic logic [FrameBits-1:0] randomFrame();
    logic [95:0] bits;
    bits = {$random(seed), $random(seed), $random(seed)};
    return bits[FrameBits-1:0];
  endfunction

  // Ray direction of one column as facing plus the floored product of plane and camera X.
  function automatic int rayModel(input int facing, input int plane, input int lane);
    real camReal;
    int  cam;
    int  prod;
    camReal = ((2.0 * lane + 1.0) / NumLanes - 1.0) * (1 << FracBits);
    cam = $rtoi(camReal);
    prod = plane * cam;
    return facing + (prod >>> FracBits);
  endfunction

  // Bit-bangs a frame MSB first; fewer bits abort it.
  task automatic sendFrame(input logic [FrameBits-1:0] data, input int bitCount);
    int i;
    waitCycles(1);
    ssN = 1'b0;
    waitCycles(HalfCycles);
    for (i = 0; i < bitCount; i++) begin
      mosi = data[FrameBits-1-i];
      sclk = 1'b0;
      waitCycles(HalfCycles);
      sclk = 1'b1;
      waitCycles(HalfCycles);
    end
    sclk = 1'b0;
    waitCycles(2 * HalfCycles);
    ssN = 1'b1;
    waitCycles(HalfCycles);
    if (bitCount == FrameBits) begin
      mReady = 1'b1;
      mBuf = data;
    end
  endtask

  task automatic checkLive();
    checkValue("playerX", playerX, mPlayerX);
    checkValue("playerY", playerY, mPlayerY);
    checkValue("facingX", facingX, mFacingX);
    checkValue("facingY", facingY, mFacingY);
    checkValue("planeX", planeX, mPlaneX);
    checkValue("planeY", planeY, mPlaneY);
  endtask

  // One tick, then the live values and the full ray burst.
  task automatic tickAndCheck(input logic px, input logic py);
    int lane;
    waitCycles(1);
    loadTick = 1'b1;
    incPx = px;
    incPy = py;
    // Override wins over the buffered load and drops the buffer.
    if (px || py) begin
      if (px) begin
        mPlayerX = mPlayerX - 15'd1;
      end
      if (py) begin
        mPlayerY = mPlayerY - 15'd1;
      end
      mReady = 1'b0;
    end else if (mReady) begin
      {mPlayerX, mPlayerY, mFacingX, mFacingY, mPlaneX, mPlaneY} = mBuf;
    end
    waitCycles(1);
    loadTick = 1'b0;
    incPx = 1'b0;
    incPy = 1'b0;
    checkLive();
    checkValue("rayValid before burst", rayValid, 0);
    repeat (2) begin
      waitCycles(1);
      checkValue("rayValid before burst", rayValid, 0);
    end
    // Burst starts 4 cycles after the tick.
    for (lane = 0; lane < NumLanes; lane++) begin
      waitCycles(1);
      checkValue("rayValid in burst", rayValid, 1);
      checkValue("rayIndex", rayIndex, lane);
      checkValue("rayDirX", rayDirX, rayModel(mFacingX, mPlaneX, lane));
      checkValue("rayDirY", rayDirY, rayModel(mFacingY, mPlaneY, lane));
    end
    waitCycles(1);
    checkValue("rayValid after burst", rayValid, 0);
  endtask

  initial begin
    #(WatchdogNs);
    $display("timeout: the tests did not finish within %0d ns", WatchdogNs);
    $display("Test failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    sclk = 1'b0;
    ssN = 1'b1;
    mosi = 1'b0;
    loadTick = 1'b0;
    incPx = 1'b0;
    incPy = 1'b0;
    mReady = 1'b0;
    mBuf = '0;
    mPlayerX = InitPlayerX;
    mPlayerY = InitPlayerY;
    mFacingX = InitFacingX;
    mFacingY = InitFacingY;
    mPlaneX = InitPlaneX;
    mPlaneY = InitPlaneY;
    frame = '0;

    waitCycles(2);
    reset = 1'b0;

    // Init values are live and no rays come before the first tick.
    checkLive();
    repeat (20) begin
      waitCycles(1);
      checkValue("rayValid idle", rayValid, 0);
    end
    tickAndCheck(1'b0, 1'b0);

    // Full frame loads, then reloads from the kept buffer.
    sendFrame(randomFrame(), FrameBits);
    tickAndCheck(1'b0, 1'b0);
    tickAndCheck(1'b0, 1'b0);

    // Aborted frame changes nothing.
    sendFrame(randomFrame(), 1 + ($unsigned($random(seed)) % (FrameBits - 1)));
    tickAndCheck(1'b0, 1'b0);

    // Positions near zero to see the wrap.
    frame = randomFrame();
    frame[FrameBits-1 -: 30] = {15'd0, 15'd1};
    sendFrame(frame, FrameBits);
    tickAndCheck(1'b0, 1'b0);
    tickAndCheck(1'b1, 1'b0);
    tickAndCheck(1'b0, 1'b1);
    tickAndCheck(1'b1, 1'b1);
    // Buffered frame was dropped by the override.
    tickAndCheck(1'b0, 1'b0);

    // Random frames with an occasional override.
    repeat (RandomRounds) begin
      sendFrame(randomFrame(), FrameBits);
      tickAndCheck(($random(seed) & 3) == 0, ($random(seed) & 3) == 0);
      tickAndCheck(1'b0, 1'b0);
    end

    $display("Test passed");
    $finish;
  end

endmodule

//--- list.f
fixedPointPkg.sv
povFramePkg.sv
spiSync.sv
povLoader.sv
rayDirLane.sv
rayCollector.sv
povRaycastTop.sv
povRaycastTb.sv

//--- run.sh
#!/bin/sh
# Build and run the POV raycast testbench with Verilator.
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module povRaycastTb -o povRaycastSim -f list.f; then
  echo "Verilator build failed"
  exit 1
fi

simOut=$(./obj_dir/povRaycastSim)
simStatus=$?
printf '%s\n' "$simOut"

if [ "$simStatus" -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if printf '%s\n' "$simOut" | grep -qx "Test passed"; then
  exit 0
fi

echo "Pass message not found in simulation output"
exit 1
